// ==== verilog/mapper_pkg.sv ====
package mapper_pkg;

	// one cpu cycle as seen by the cartridge
	typedef struct packed {
		logic [14:0] addr;
		logic [7:0] dat;
		logic rw; // high on reads
		logic ce; // low selects rom area 8000-ffff
	} cpu_bus_t;

	typedef struct packed {
		logic [13:0] addr;
		logic oe; // active low
		logic we; // active low
	} ppu_bus_t;

	// save-state side bus
	typedef struct packed {
		logic act;
		logic we;
		logic [7:0] addr;
		logic [7:0] dat;
	} ss_bus_t;

	typedef struct packed {
		logic [7:0] chr0; // 2k pair, bit 0 from ppu a11
		logic [7:0] chr1; // 2k pair, bit 0 from ppu a11
		logic [7:0] chr2;
		logic [7:0] chr3;
		logic [7:0] chr4;
		logic [7:0] chr5;
		logic [7:0] prg0;
		logic [7:0] prg1;
		logic prg_mode;
		logic chr_a12; // swaps the chr halves
		logic mirror; // 0 vertical, 1 horizontal
		logic [1:0] ram_protect; // [1] wram enable, [0] write protect
	} bank_regs_t;

	typedef struct packed {
		logic [18:0] prg_addr;
		logic [18:0] chr_addr;
		logic prg_oe;
		logic chr_oe;
		logic chr_we;
		logic chr_ce;
		logic ciram_a10;
		logic ciram_ce;
		logic ram_ce;
		logic ram_we;
		logic [12:0] srm_addr;
	} mem_ctrl_t;

	localparam logic [7:0] MAP_IDX = 8'd197;

	// register codes, {cpu a14:a13, a0}
	localparam logic [2:0] REG_SELECT = 3'd0;
	localparam logic [2:0] REG_BANK = 3'd1;
	localparam logic [2:0] REG_MIRROR = 3'd2;
	localparam logic [2:0] REG_RAM_PROT = 3'd3;
	localparam logic [2:0] REG_LATCH = 3'd4;
	localparam logic [2:0] REG_RELOAD = 3'd5;
	localparam logic [2:0] REG_IRQ_DIS = 3'd6; // also acknowledges
	localparam logic [2:0] REG_IRQ_EN = 3'd7;

	// save-state slots
	localparam logic [7:0] SS_ADDR_PRG0 = 8'd0;
	localparam logic [7:0] SS_ADDR_PRG1 = 8'd1;
	localparam logic [7:0] SS_ADDR_CHR0 = 8'd2;
	localparam logic [7:0] SS_ADDR_CHR1 = 8'd3;
	localparam logic [7:0] SS_ADDR_CHR2 = 8'd4;
	localparam logic [7:0] SS_ADDR_CHR3 = 8'd5;
	localparam logic [7:0] SS_ADDR_CHR4 = 8'd6;
	localparam logic [7:0] SS_ADDR_CHR5 = 8'd7;
	localparam logic [7:0] SS_ADDR_CTRL = 8'd8;
	localparam logic [7:0] SS_ADDR_A12 = 8'd10;
	localparam logic [7:0] SS_ADDR_LATCH = 8'd11;
	localparam logic [7:0] SS_ADDR_IRQ = 8'd12;
	localparam logic [7:0] SS_ADDR_IDX = 8'd127;

endpackage

// ==== verilog/mmc3_regs.sv ====
module mmc3_regs (
	input logic m2,
	input logic map_rst,
	input mapper_pkg::cpu_bus_t cpu,
	input mapper_pkg::ss_bus_t ss,
	output mapper_pkg::bank_regs_t regs,
	output logic latch_wr,
	output logic [7:0] latch_dat,
	output logic reload_req,
	output logic irq_disable,
	output logic irq_enable,
	output logic [7:0] ss_rdat
);
	import mapper_pkg::*;

	logic [2:0] select; // bank data pointer
	logic ss_wr;
	logic cpu_wr;
	logic [2:0] reg_code;

	assign ss_wr = ss.act & ss.we;
	assign cpu_wr = !cpu.ce & !cpu.rw & !ss_wr; // save-state write owns the cycle
	assign reg_code = {cpu.addr[14:13], cpu.addr[0]};

	// irq register writes leave as strobes
	assign latch_wr = cpu_wr & (reg_code == REG_LATCH);
	assign reload_req = cpu_wr & (reg_code == REG_RELOAD);
	assign irq_disable = cpu_wr & (reg_code == REG_IRQ_DIS);
	assign irq_enable = cpu_wr & (reg_code == REG_IRQ_EN);
	assign latch_dat = cpu.dat;

	always_ff @(posedge m2) begin
		if (map_rst) begin
			regs <= '0;
			select <= '0;
		end else if (ss_wr) begin
			case (ss.addr)
				SS_ADDR_PRG0: regs.prg0 <= ss.dat;
				SS_ADDR_PRG1: regs.prg1 <= ss.dat;
				SS_ADDR_CHR0: regs.chr0 <= ss.dat;
				SS_ADDR_CHR1: regs.chr1 <= ss.dat;
				SS_ADDR_CHR2: regs.chr2 <= ss.dat;
				SS_ADDR_CHR3: regs.chr3 <= ss.dat;
				SS_ADDR_CHR4: regs.chr4 <= ss.dat;
				SS_ADDR_CHR5: regs.chr5 <= ss.dat;
				SS_ADDR_CTRL: begin
					regs.chr_a12 <= ss.dat[0];
					regs.prg_mode <= ss.dat[1];
					regs.mirror <= ss.dat[2];
					select <= ss.dat[5:3];
					regs.ram_protect <= ss.dat[7:6];
				end
				default: ;
			endcase
		end else if (cpu_wr) begin
			case (reg_code)
				REG_SELECT: begin // 8000
					select <= cpu.dat[2:0];
					regs.prg_mode <= cpu.dat[6];
					regs.chr_a12 <= cpu.dat[7];
				end
				REG_BANK: begin // 8001
					case (select)
						3'd0: regs.chr0[7:1] <= cpu.dat[7:1]; // bit 0 from ppu a11
						3'd1: regs.chr1[7:1] <= cpu.dat[7:1];
						3'd2: regs.chr2 <= cpu.dat;
						3'd3: regs.chr3 <= cpu.dat;
						3'd4: regs.chr4 <= cpu.dat;
						3'd5: regs.chr5 <= cpu.dat;
						3'd6: regs.prg0[5:0] <= cpu.dat[5:0]; // 512k window
						default: regs.prg1[5:0] <= cpu.dat[5:0];
					endcase
				end
				REG_MIRROR: regs.mirror <= cpu.dat[0]; // a000
				REG_RAM_PROT: regs.ram_protect <= cpu.dat[7:6]; // a001
				default: ;
			endcase
		end
	end

	// save-state readback, slots outside this block read ff
	always_comb begin
		case (ss.addr)
			SS_ADDR_PRG0: ss_rdat = regs.prg0;
			SS_ADDR_PRG1: ss_rdat = regs.prg1;
			SS_ADDR_CHR0: ss_rdat = regs.chr0;
			SS_ADDR_CHR1: ss_rdat = regs.chr1;
			SS_ADDR_CHR2: ss_rdat = regs.chr2;
			SS_ADDR_CHR3: ss_rdat = regs.chr3;
			SS_ADDR_CHR4: ss_rdat = regs.chr4;
			SS_ADDR_CHR5: ss_rdat = regs.chr5;
			SS_ADDR_CTRL: begin
				ss_rdat = {regs.ram_protect, select, regs.mirror, regs.prg_mode,
					regs.chr_a12};
			end
			SS_ADDR_IDX: ss_rdat = MAP_IDX;
			default: ss_rdat = 8'hff;
		endcase
	end

	// the irq block relies on seeing one command per cycle
	a_one_irq_strobe: assert property (@(posedge m2) disable iff (map_rst)
		$onehot0({latch_wr, reload_req, irq_disable, irq_enable}));

endmodule

// ==== verilog/mmc3_addr_map.sv ====
module mmc3_addr_map #(
	parameter int PRG_BANK_W = 6,
	parameter int CHR_BANK_W = 8
) (
	input mapper_pkg::cpu_bus_t cpu,
	input mapper_pkg::ppu_bus_t ppu,
	input mapper_pkg::bank_regs_t regs,
	output mapper_pkg::mem_ctrl_t mem
);
	localparam logic CHR_RAM = 1'b1; // board carries chr ram only
	localparam logic [PRG_BANK_W-1:0] PRG_LAST = '1;
	localparam logic [PRG_BANK_W-1:0] PRG_PENULT = PRG_LAST - 1'b1;

	logic [PRG_BANK_W-1:0] prg_bank;
	logic [CHR_BANK_W-1:0] chr_bank;
	logic chr_area;
	logic ram_sel;

	// prg slots 8000/a000/c000/e000
	always_comb begin
		if (cpu.ce) begin
			prg_bank = '0; // not a rom cycle
		end else begin
			case ({regs.prg_mode, cpu.addr[14:13]})
				3'b000: prg_bank = regs.prg0[PRG_BANK_W-1:0];
				3'b001: prg_bank = regs.prg1[PRG_BANK_W-1:0];
				3'b010: prg_bank = PRG_PENULT;
				3'b100: prg_bank = PRG_PENULT; // mode 1 swaps 8000 and c000
				3'b101: prg_bank = regs.prg1[PRG_BANK_W-1:0];
				3'b110: prg_bank = regs.prg0[PRG_BANK_W-1:0];
				default: prg_bank = PRG_LAST;
			endcase
		end
	end

	// chr in 2k pairs, the low half pairs its bank with a11
	always_comb begin
		if (!ppu.addr[12]) begin
			if (regs.chr_a12)
				chr_bank = {regs.chr2[CHR_BANK_W-1:1], ppu.addr[11]};
			else
				chr_bank = {regs.chr0[CHR_BANK_W-1:1], ppu.addr[11]};
		end else if (regs.chr_a12) begin
			chr_bank = regs.chr0[CHR_BANK_W-1:0]; // both quarters
		end else if (!ppu.addr[11]) begin
			chr_bank = regs.chr2[CHR_BANK_W-1:0];
		end else begin
			chr_bank = regs.chr3[CHR_BANK_W-1:0];
		end
	end

	assign chr_area = !ppu.addr[13]; // pattern tables 0000-1fff
	assign ram_sel = regs.ram_protect[1] & (cpu.addr[14:13] == 2'b11) & cpu.ce;

	always_comb begin
		mem.prg_addr = 19'({prg_bank, cpu.addr[12:0]});
		mem.prg_oe = cpu.rw;
		mem.chr_addr = 19'({chr_bank, ppu.addr[10:0]});
		mem.chr_oe = !ppu.oe;
		mem.chr_ce = chr_area;
		mem.chr_we = CHR_RAM & !ppu.we & chr_area;
		mem.ciram_a10 = regs.mirror ? ppu.addr[11] : ppu.addr[10];
		mem.ciram_ce = !chr_area; // nametables 2000-3fff
		mem.ram_ce = ram_sel; // 6000-7fff
		mem.ram_we = ram_sel & !cpu.rw & !regs.ram_protect[0];
		mem.srm_addr = cpu.addr[12:0];
	end

endmodule

// ==== verilog/mmc3_scanline_irq.sv ====
module mmc3_scanline_irq (
	input logic m2,
	input logic map_rst,
	input logic a12,
	input logic latch_wr,
	input logic [7:0] latch_dat,
	input logic reload_req,
	input logic irq_disable,
	input logic irq_enable,
	input mapper_pkg::ss_bus_t ss,
	output logic irq,
	output logic [7:0] ss_rdat,
	output logic ss_hit
);
	import mapper_pkg::*;

	logic [7:0] a12_hist; // newest sample in bit 0
	logic [7:0] counter;
	logic [7:0] latch;
	logic reload_pend;
	logic irq_en;
	logic irq_pend;
	logic ss_wr;
	logic cnt_clk;
	logic reload;

	assign ss_wr = ss.act & ss.we;
	// four lows then a high, so one clock per filtered rise
	assign cnt_clk = (a12_hist[4:0] == 5'b00001) & !ss.act;
	assign reload = reload_pend | (counter == 8'd0);

	always_ff @(posedge m2) begin
		if (map_rst) begin
			a12_hist <= '0;
			counter <= '0;
			latch <= '0;
			reload_pend <= 1'b0;
			irq_en <= 1'b0;
			irq_pend <= 1'b0;
		end else if (ss_wr) begin
			case (ss.addr)
				SS_ADDR_A12: a12_hist <= ss.dat;
				SS_ADDR_LATCH: latch <= ss.dat;
				SS_ADDR_IRQ: begin
					irq_en <= ss.dat[0];
					irq_pend <= ss.dat[2];
					reload_pend <= ss.dat[4];
				end
				default: ;
			endcase
		end else begin
			if (!ss.act)
				a12_hist <= {a12_hist[6:0], a12};
			if (cnt_clk) begin
				counter <= reload ? latch : counter - 8'd1;
				if (irq_en & (reload ? (latch == 8'd0) : (counter == 8'd1)))
					irq_pend <= 1'b1;
			end
			if (reload_req)
				reload_pend <= 1'b1; // takes effect on the next clock
			else if (cnt_clk)
				reload_pend <= 1'b0;
			if (latch_wr)
				latch <= latch_dat;
			if (irq_disable) begin
				irq_en <= 1'b0;
				irq_pend <= 1'b0; // acknowledge
			end else if (irq_enable) begin
				irq_en <= 1'b1;
			end
		end
	end

	assign irq = irq_pend;
	assign ss_hit = (ss.addr == SS_ADDR_A12) | (ss.addr == SS_ADDR_LATCH) |
		(ss.addr == SS_ADDR_IRQ);

	always_comb begin
		case (ss.addr)
			SS_ADDR_A12: ss_rdat = a12_hist;
			SS_ADDR_LATCH: ss_rdat = latch;
			default: ss_rdat = {3'b000, reload_pend, 1'b0, irq_pend, 1'b0, irq_en};
		endcase
	end

	// only a state restore may raise irq without the enable
	a_irq_needs_enable: assert property (@(posedge m2) disable iff (map_rst)
		$rose(irq) |-> $past(irq_en) || $past(ss_wr));

endmodule

// ==== verilog/map_197_top.sv ====
module map_197_top #(
	parameter int PRG_BANK_W = 6,
	parameter int CHR_BANK_W = 8
) (
	input logic m2,
	input logic map_rst,
	input mapper_pkg::cpu_bus_t cpu,
	input mapper_pkg::ppu_bus_t ppu,
	input mapper_pkg::ss_bus_t ss,
	output mapper_pkg::mem_ctrl_t mem,
	output logic irq,
	output logic [7:0] ss_rdat
);
	import mapper_pkg::*;

	bank_regs_t regs;
	mem_ctrl_t map_mem;
	logic latch_wr;
	logic [7:0] latch_dat;
	logic reload_req;
	logic irq_disable;
	logic irq_enable;
	logic [7:0] regs_rdat;
	logic [7:0] irq_rdat;
	logic irq_hit;

	mmc3_regs mmc3_regs_inst (
		.m2(m2),
		.map_rst(map_rst),
		.cpu(cpu),
		.ss(ss),
		.regs(regs),
		.latch_wr(latch_wr),
		.latch_dat(latch_dat),
		.reload_req(reload_req),
		.irq_disable(irq_disable),
		.irq_enable(irq_enable),
		.ss_rdat(regs_rdat)
	);

	mmc3_addr_map #(
		.PRG_BANK_W(PRG_BANK_W),
		.CHR_BANK_W(CHR_BANK_W)
	) mmc3_addr_map_inst (
		.cpu(cpu),
		.ppu(ppu),
		.regs(regs),
		.mem(map_mem)
	);

	mmc3_scanline_irq mmc3_scanline_irq_inst (
		.m2(m2),
		.map_rst(map_rst),
		.a12(ppu.addr[12]),
		.latch_wr(latch_wr),
		.latch_dat(latch_dat),
		.reload_req(reload_req),
		.irq_disable(irq_disable),
		.irq_enable(irq_enable),
		.ss(ss),
		.irq(irq),
		.ss_rdat(irq_rdat),
		.ss_hit(irq_hit)
	);

	// wram strobes only in the high phase of m2
	always_comb begin
		mem = map_mem;
		mem.ram_ce = map_mem.ram_ce & m2;
		mem.ram_we = map_mem.ram_we & m2;
	end

	assign ss_rdat = irq_hit ? irq_rdat : regs_rdat; // irq slots win
endmodule

// ==== verif/tb_clock.sv ====
module tb_clock (
	output logic m2,
	output logic map_rst
);
	initial begin
		m2 = 1'b0;
		map_rst = 1'b1;
		repeat (4) @(posedge m2); // reset spans four rising edges
		map_rst <= 1'b0;
	end

	always #50 m2 = ~m2;

endmodule

// ==== verif/map_197_tb.sv ====
module map_197_tb;
	import mapper_pkg::*;

	localparam int TBL_MAX = 96;
	localparam int OP_WR = 0; // cpu register write
	localparam int OP_CPU = 1; // cpu address probe
	localparam int OP_PPU = 2; // ppu address probe
	localparam int OP_A12 = 3; // a12 pulse train, data = rises
	localparam int OP_SSW = 4;
	localparam int OP_SSR = 5;
	localparam int OP_IRQ = 6;
	localparam cpu_bus_t CPU_IDLE = {15'd0, 8'd0, 1'b1, 1'b1};
	localparam ss_bus_t SS_IDLE = '0;

	logic m2;
	logic map_rst;
	cpu_bus_t cpu;
	ppu_bus_t ppu;
	ss_bus_t ss;
	mem_ctrl_t mem;
	logic irq;
	logic [7:0] ss_rdat;

	int ops [0:TBL_MAX-1];
	logic [15:0] addrs [0:TBL_MAX-1];
	logic [15:0] datas [0:TBL_MAX-1];
	logic [15:0] exps [0:TBL_MAX-1];
	string names [0:TBL_MAX-1];
	int n_ent;
	int total_cost;
	int limit = 100000;
	int cycles = 0;
	logic [31:0] lfsr_state;

	// reference state of the mapper registers
	logic [7:0] m_chr [0:5];
	logic [7:0] m_prg0;
	logic [7:0] m_prg1;
	logic [2:0] m_sel;
	logic m_mode;
	logic m_chr_a12;
	logic m_mirror;

	tb_clock tb_clock_inst (
		.m2(m2),
		.map_rst(map_rst)
	);

	map_197_top map_197_top_inst (
		.m2(m2),
		.map_rst(map_rst),
		.cpu(cpu),
		.ppu(ppu),
		.ss(ss),
		.mem(mem),
		.irq(irq),
		.ss_rdat(ss_rdat)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
	endfunction

	task automatic rand_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
	endtask

	task automatic model_write(input logic [15:0] a, input logic [15:0] d);
		case ({a[14:13], a[0]})
			3'd0: begin
				m_sel = d[2:0];
				m_mode = d[6];
				m_chr_a12 = d[7];
			end
			3'd1: begin
				if (m_sel < 2)
					m_chr[m_sel][7:1] = d[7:1]; // 2k pairs keep bit 0
				else if (m_sel < 6)
					m_chr[m_sel] = d[7:0];
				else if (m_sel == 6)
					m_prg0[5:0] = d[5:0];
				else
					m_prg1[5:0] = d[5:0];
			end
			3'd2: m_mirror = d[0];
			default: ;
		endcase
	endtask

	// expected {ram_ce, ram_we, prg bank} for a rom read
	function automatic logic [15:0] prg_exp(input logic [15:0] a);
		logic [1:0] slot;
		slot = a[14:13];
		if (m_mode && !slot[0])
			slot = slot ^ 2'b10; // mode 1 trades 8000 and c000
		case (slot)
			2'd0: return {10'd0, m_prg0[5:0]};
			2'd1: return {10'd0, m_prg1[5:0]};
			2'd2: return 16'd62; // second-last of 64
			default: return 16'd63;
		endcase
	endfunction

	// expected {chr_oe, chr_ce, chr_we, ciram_ce, ciram_a10, chr bank}
	function automatic logic [15:0] chr_exp(input logic [15:0] a, input logic rd);
		logic [7:0] bank;
		logic pattern;
		pattern = !a[13]; // 0000-1fff goes to chr ram, the rest to ciram
		if (!a[12])
			bank = {(m_chr_a12 ? m_chr[2][7:1] : m_chr[0][7:1]), a[11]};
		else if (m_chr_a12)
			bank = m_chr[0];
		else
			bank = a[11] ? m_chr[3] : m_chr[2];
		return {3'd0, rd, pattern, pattern & !rd, !pattern, (m_mirror ? a[11] : a[10]), bank};
	endfunction

	task automatic add_entry(input int op, input logic [15:0] a, input logic [15:0] d,
		input logic [15:0] e, input string name);
		ops[n_ent] = op;
		addrs[n_ent] = a;
		datas[n_ent] = d;
		exps[n_ent] = e;
		names[n_ent] = name;
		case (op)
			OP_WR: begin
				total_cost += 2;
				model_write(a, d);
			end
			OP_A12: total_cost += 7 * int'(d) + 1;
			OP_SSW, OP_SSR: total_cost += 2;
			default: total_cost += 1;
		endcase
		n_ent++;
	endtask

	task automatic build_table();
		logic [15:0] r;
		logic [15:0] saved [0:7];
		m_chr = '{default: 8'd0};
		m_prg0 = 8'd0;
		m_prg1 = 8'd0;
		m_sel = 3'd0;
		m_mode = 1'b0;
		m_chr_a12 = 1'b0;
		m_mirror = 1'b0;
		// prg banking, mode 0 then mode 1
		add_entry(OP_WR, 16'h8000, 16'h06, 0, "select prg0");
		rand_bits(8, r);
		add_entry(OP_WR, 16'h8001, r, 0, "prg0 data");
		add_entry(OP_WR, 16'h8000, 16'h07, 0, "select prg1");
		rand_bits(8, r);
		add_entry(OP_WR, 16'h8001, r, 0, "prg1 data");
		for (int m = 0; m < 2; m++) begin
			if (m == 1)
				add_entry(OP_WR, 16'h8000, 16'h46, 0, "prg mode 1");
			for (int s = 0; s < 4; s++)
				add_entry(OP_CPU, 16'h8000 + 16'(s) * 16'h2000, 1,
					prg_exp(16'h8000 + 16'(s) * 16'h2000), $sformatf("prg m%0d s%0d", m, s));
		end
		// chr banking, both a12 settings, writes then reads
		for (int c = 0; c < 4; c++) begin
			add_entry(OP_WR, 16'h8000, 16'(c), 0, "select chr");
			rand_bits(8, r);
			add_entry(OP_WR, 16'h8001, r, 0, $sformatf("chr%0d data", c));
		end
		for (int h = 0; h < 2; h++) begin
			if (h == 1)
				add_entry(OP_WR, 16'h8000, 16'h80, 0, "chr a12 invert");
			for (int q = 0; q < 4; q++)
				add_entry(OP_PPU, 16'(q) * 16'h0800 + 16'h0400, 16'(h),
					chr_exp(16'(q) * 16'h0800 + 16'h0400, h[0]),
					$sformatf("chr h%0d q%0d", h, q));
		end
		// mirroring
		add_entry(OP_WR, 16'hA000, 16'h01, 0, "mirror set");
		add_entry(OP_PPU, 16'h0400, 1, chr_exp(16'h0400, 1'b1), "mirror a10");
		add_entry(OP_PPU, 16'h0800, 1, chr_exp(16'h0800, 1'b1), "mirror a11");
		add_entry(OP_PPU, 16'h2C00, 0, chr_exp(16'h2C00, 1'b0), "nametable write");
		// wram gating, cpu probe data bit 0 is rw
		add_entry(OP_CPU, 16'h6000, 0, 16'h00, "wram off after reset");
		add_entry(OP_WR, 16'hA001, 16'h80, 0, "wram enable");
		add_entry(OP_CPU, 16'h6000, 0, 16'hC0, "wram write open");
		add_entry(OP_CPU, 16'h7FFF, 1, 16'h80, "wram read");
		add_entry(OP_WR, 16'hA001, 16'hC0, 0, "wram protect");
		add_entry(OP_CPU, 16'h6000, 0, 16'h80, "wram write blocked");
		// scanline irq with latch 3
		add_entry(OP_WR, 16'hC000, 16'h03, 0, "irq latch");
		add_entry(OP_WR, 16'hC001, 16'h00, 0, "irq reload");
		add_entry(OP_WR, 16'hE001, 16'h00, 0, "irq enable");
		add_entry(OP_A12, 0, 3, 0, "three rises");
		add_entry(OP_IRQ, 0, 0, 0, "irq low after n");
		add_entry(OP_A12, 0, 1, 0, "one more rise");
		add_entry(OP_IRQ, 0, 0, 1, "irq high after n+1");
		add_entry(OP_WR, 16'hE000, 16'h00, 0, "irq ack");
		add_entry(OP_IRQ, 0, 0, 0, "irq cleared");
		add_entry(OP_A12, 0, 5, 0, "rises while disabled");
		add_entry(OP_IRQ, 0, 0, 0, "irq stays low");
		// save state
		for (int i = 0; i < 8; i++) begin
			rand_bits(8, r);
			saved[i] = r;
			add_entry(OP_SSW, 16'(i), r, 0, $sformatf("ss write %0d", i));
		end
		for (int i = 0; i < 8; i++)
			add_entry(OP_SSR, 16'(i), 0, saved[i], $sformatf("ss read %0d", i));
		add_entry(OP_SSR, 16'd127, 0, 16'd197, "ss mapper index");
		add_entry(OP_SSR, 16'd9, 0, 16'hFF, "ss unused slot");
	endtask

	task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("error: %s expected %h actual %h", name, exp, act);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic a12_rises(input int n);
		repeat (n) begin
			@(posedge m2);
			ppu.addr[12] <= 1'b0;
			repeat (4) @(posedge m2); // five low samples before the rise
			@(posedge m2);
			ppu.addr[12] <= 1'b1;
			@(posedge m2);
		end
		@(posedge m2);
		ppu.addr[12] <= 1'b0;
	endtask

	task automatic run_entry(input int i);
		case (ops[i])
			OP_WR: begin
				@(posedge m2);
				cpu <= {addrs[i][14:0], datas[i][7:0], 1'b0, 1'b0};
				@(posedge m2);
				cpu <= CPU_IDLE;
			end
			OP_CPU: begin
				@(posedge m2);
				cpu <= {addrs[i][14:0], 8'd0, datas[i][0], !addrs[i][15]};
				#25; // m2 high, wram strobes live
				check(names[i], exps[i], {8'd0, mem.ram_ce, mem.ram_we, mem.prg_addr[18:13]});
			end
			OP_PPU: begin
				@(posedge m2);
				ppu <= {addrs[i][13:0], !datas[i][0], datas[i][0]}; // data bit 0 set reads
				#25;
				check(names[i], exps[i], {3'd0, mem.chr_oe, mem.chr_ce, mem.chr_we,
					mem.ciram_ce, mem.ciram_a10, mem.chr_addr[18:11]});
			end
			OP_A12: a12_rises(int'(datas[i]));
			OP_SSW: begin
				@(posedge m2);
				ss <= {1'b1, 1'b1, addrs[i][7:0], datas[i][7:0]};
				@(posedge m2);
				ss <= SS_IDLE;
			end
			OP_SSR: begin
				@(posedge m2);
				ss <= {1'b1, 1'b0, addrs[i][7:0], 8'd0};
				#25;
				check(names[i], exps[i], {8'd0, ss_rdat});
				@(posedge m2);
				ss <= SS_IDLE;
			end
			default: begin
				@(posedge m2);
				#25;
				check(names[i], exps[i], {15'd0, irq});
			end
		endcase
	endtask

	always @(posedge m2) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: run exceeded %0d cycles", limit);
			$display("CHECKS FAILED");
			$fatal(1, "run did not finish in time");
		end
	end

	initial begin
		cpu = CPU_IDLE;
		ppu = {14'd0, 1'b1, 1'b1};
		ss = SS_IDLE;
		lfsr_state = 32'hf25fd6e0;
		n_ent = 0;
		total_cost = 0;
		build_table();
		limit = total_cost + 4 + 20; // reset cycles and some slack
		@(negedge map_rst);
		for (int i = 0; i < n_ent; i++)
			run_entry(i);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== build.f ====
verilog/mapper_pkg.sv
verilog/mmc3_regs.sv
verilog/mmc3_addr_map.sv
verilog/mmc3_scanline_irq.sv
verilog/map_197_top.sv
verif/tb_clock.sv
verif/map_197_tb.sv
